//--- source/fpss_pkg.sv
package fpss_pkg;

  // Widths with a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] hart_id_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  fflags_t;
  typedef logic [2:0]  frm_t;

  localparam int unsigned FifoDepth = 2;

  localparam logic [6:0] OpcodeOpFp   = 7'b1010011;
  localparam logic [6:0] OpcodeSystem = 7'b1110011;

  // Single-precision funct7 values
  localparam logic [6:0] Funct7Fsgnj   = 7'b0010000;
  localparam logic [6:0] Funct7Fminmax = 7'b0010100;
  localparam logic [6:0] Funct7Fcmp    = 7'b1010000;
  localparam logic [6:0] Funct7FmvXW   = 7'b1110000;
  localparam logic [6:0] Funct7FmvWX   = 7'b1111000;

  localparam csr_addr_t CsrFflags = 12'h001;
  localparam csr_addr_t CsrFrm    = 12'h002;
  localparam csr_addr_t CsrFcsr   = 12'h003;

  localparam word_t CanonicalNan = 32'h7FC0_0000;

  typedef enum logic [3:0] {
    OpSgnj,
    OpSgnjn,
    OpSgnjx,
    OpMin,
    OpMax,
    OpFeq,
    OpFlt,
    OpFle,
    OpMvXW,
    OpMvWX,
    OpCsrRw,
    OpCsrRs,
    OpCsrRc,
    OpIllegal
  } fp_op_e;

  typedef struct packed {
    word_t    instr;
    word_t    rs1_val;
    hart_id_t hart_id;
  } offload_req_t;

  typedef struct packed {
    fp_op_e    op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rd_is_fp;
    csr_addr_t csr_addr;
    word_t     int_val;
  } decoded_t;

  typedef struct packed {
    word_t     data;
    reg_addr_t rd;
    hart_id_t  hart_id;
    logic      error;
  } resp_t;

  // Exponent all ones with a nonzero mantissa
  function automatic logic is_nan(word_t w);
    return (w[30:23] == 8'hFF) && (w[22:0] != '0);
  endfunction

  // Signaling NaNs have the quiet bit clear
  function automatic logic is_snan(word_t w);
    return is_nan(w) && !w[22];
  endfunction

endpackage

//--- source/fpss_offload_fifo.sv
module fpss_offload_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_valid_i,
  input  fpss_pkg::offload_req_t push_i,
  output logic                  push_ready_o,
  output logic                  head_valid_o,
  output fpss_pkg::offload_req_t head_o,
  input  logic                  pop_i
);
  import fpss_pkg::*;

  typedef logic [$clog2(FifoDepth)-1:0]   ptr_t;
  typedef logic [$clog2(FifoDepth+1)-1:0] cnt_t;

  offload_req_t mem [FifoDepth];
  ptr_t         wr_ptr_q;
  ptr_t         rd_ptr_q;
  cnt_t         count_q;
  logic         push;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push_ready_o = (count_q != cnt_t'(FifoDepth));
  assign push         = push_valid_i && push_ready_o;
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem[rd_ptr_q];

  // Storage only, pointers tell what is valid
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= push_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_o);

  count_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_t'(FifoDepth));

endmodule

//--- source/fpss_decoder.sv
module fpss_decoder (
  input  fpss_pkg::word_t    instr_i,
  input  fpss_pkg::word_t    rs1_val_i,
  output fpss_pkg::decoded_t dec_o
);
  import fpss_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_addr_t  rs2_field;
  csr_addr_t  csr_addr;
  logic       csr_known;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rs2_field = instr_i[24:20];
  assign csr_addr  = instr_i[31:20];
  assign csr_known = (csr_addr == CsrFflags) || (csr_addr == CsrFrm) ||
                     (csr_addr == CsrFcsr);

  always_comb begin
    dec_o          = '0;
    dec_o.op       = OpIllegal;
    dec_o.rd       = instr_i[11:7];
    dec_o.rs1      = instr_i[19:15];
    dec_o.rs2      = rs2_field;
    dec_o.csr_addr = csr_addr;
    dec_o.int_val  = rs1_val_i;

    if (opcode == OpcodeOpFp) begin
      case (funct7)
        Funct7Fsgnj: begin
          case (funct3)
            3'b000:  dec_o.op = OpSgnj;
            3'b001:  dec_o.op = OpSgnjn;
            3'b010:  dec_o.op = OpSgnjx;
            default: dec_o.op = OpIllegal;
          endcase
        end
        Funct7Fminmax: begin
          case (funct3)
            3'b000:  dec_o.op = OpMin;
            3'b001:  dec_o.op = OpMax;
            default: dec_o.op = OpIllegal;
          endcase
        end
        Funct7Fcmp: begin
          case (funct3)
            3'b010:  dec_o.op = OpFeq;
            3'b001:  dec_o.op = OpFlt;
            3'b000:  dec_o.op = OpFle;
            default: dec_o.op = OpIllegal;
          endcase
        end
        // Moves need rs2 zero, FCLASS shares the funct7 but is not kept
        Funct7FmvXW: begin
          if (funct3 == 3'b000 && rs2_field == '0) begin
            dec_o.op = OpMvXW;
          end
        end
        Funct7FmvWX: begin
          if (funct3 == 3'b000 && rs2_field == '0) begin
            dec_o.op = OpMvWX;
          end
        end
        default: dec_o.op = OpIllegal;
      endcase
    end else if (opcode == OpcodeSystem && csr_known) begin
      // Register forms only
      case (funct3)
        3'b001:  dec_o.op = OpCsrRw;
        3'b010:  dec_o.op = OpCsrRs;
        3'b011:  dec_o.op = OpCsrRc;
        default: dec_o.op = OpIllegal;
      endcase
    end

    dec_o.rd_is_fp = (dec_o.op == OpSgnj) || (dec_o.op == OpSgnjn) ||
                     (dec_o.op == OpSgnjx) || (dec_o.op == OpMin) ||
                     (dec_o.op == OpMax) || (dec_o.op == OpMvWX);
  end

endmodule

//--- source/fpss_regfile.sv
module fpss_regfile (
  input  logic                clk_i,
  input  fpss_pkg::reg_addr_t raddr_a_i,
  input  fpss_pkg::reg_addr_t raddr_b_i,
  output fpss_pkg::word_t     rdata_a_o,
  output fpss_pkg::word_t     rdata_b_o,
  input  logic                we_i,
  input  fpss_pkg::reg_addr_t waddr_i,
  input  fpss_pkg::word_t     wdata_i
);
  import fpss_pkg::*;

  word_t regs [32];

  // Asynchronous reads
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- source/fpss_exec.sv
module fpss_exec (
  input  fpss_pkg::decoded_t dec_i,
  input  fpss_pkg::word_t    op_a_i,
  input  fpss_pkg::word_t    op_b_i,
  output fpss_pkg::word_t    fp_result_o,
  output fpss_pkg::word_t    int_result_o,
  output fpss_pkg::fflags_t  flags_o
);
  import fpss_pkg::*;

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic any_nan;
  logic a_lt_b;
  logic a_eq_b;
  logic nv;

  assign a_nan   = is_nan(op_a_i);
  assign b_nan   = is_nan(op_b_i);
  assign a_snan  = is_snan(op_a_i);
  assign b_snan  = is_snan(op_b_i);
  assign any_nan = a_nan || b_nan;

  // Signed-magnitude order, -0 sits below +0
  always_comb begin
    if (op_a_i[31] != op_b_i[31]) begin
      a_lt_b = op_a_i[31];
    end else if (op_a_i[31]) begin
      a_lt_b = op_a_i[30:0] > op_b_i[30:0];
    end else begin
      a_lt_b = op_a_i[30:0] < op_b_i[30:0];
    end
  end

  // Compares treat both zeros as equal
  assign a_eq_b = (op_a_i == op_b_i) || ((op_a_i[30:0] | op_b_i[30:0]) == '0);

  always_comb begin
    fp_result_o  = op_a_i;
    int_result_o = '0;
    nv           = 1'b0;
    case (dec_i.op)
      OpSgnj:  fp_result_o = {op_b_i[31], op_a_i[30:0]};
      OpSgnjn: fp_result_o = {~op_b_i[31], op_a_i[30:0]};
      OpSgnjx: fp_result_o = {op_a_i[31] ^ op_b_i[31], op_a_i[30:0]};
      OpMin, OpMax: begin
        nv = a_snan || b_snan;
        if (a_nan && b_nan) begin
          fp_result_o = CanonicalNan;
        end else if (a_nan) begin
          fp_result_o = op_b_i;
        end else if (b_nan) begin
          fp_result_o = op_a_i;
        end else if (a_lt_b == (dec_i.op == OpMin)) begin
          fp_result_o = op_a_i;
        end else begin
          fp_result_o = op_b_i;
        end
      end
      OpFeq: begin
        nv           = a_snan || b_snan;
        int_result_o = {31'b0, a_eq_b && !any_nan};
      end
      // Ordered compares flag quiet NaNs too
      OpFlt: begin
        nv           = any_nan;
        int_result_o = {31'b0, a_lt_b && !a_eq_b && !any_nan};
      end
      OpFle: begin
        nv           = any_nan;
        int_result_o = {31'b0, (a_lt_b || a_eq_b) && !any_nan};
      end
      OpMvXW:  int_result_o = op_a_i;
      OpMvWX:  fp_result_o  = dec_i.int_val;
      default: ;
    endcase
  end

  // NV, DZ, OF, UF, NX
  assign flags_o = {nv, 4'b0000};

endmodule

//--- source/fpss_csr.sv
module fpss_csr (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  fpss_pkg::decoded_t dec_i,
  input  fpss_pkg::fflags_t  flags_i,
  output fpss_pkg::word_t    rdata_o
);
  import fpss_pkg::*;

  fflags_t fflags_q;
  fflags_t fflags_d;
  frm_t    frm_q;
  frm_t    frm_d;
  word_t   wdata;
  logic    is_csr_op;

  assign is_csr_op = (dec_i.op == OpCsrRw) || (dec_i.op == OpCsrRs) ||
                     (dec_i.op == OpCsrRc);

  // Old value, zero-extended
  always_comb begin
    case (dec_i.csr_addr)
      CsrFflags: rdata_o = {27'b0, fflags_q};
      CsrFrm:    rdata_o = {29'b0, frm_q};
      CsrFcsr:   rdata_o = {24'b0, frm_q, fflags_q};
      default:   rdata_o = '0;
    endcase
  end

  always_comb begin
    case (dec_i.op)
      OpCsrRs: wdata = rdata_o | dec_i.int_val;
      OpCsrRc: wdata = rdata_o & ~dec_i.int_val;
      default: wdata = dec_i.int_val;
    endcase
  end

  always_comb begin
    fflags_d = fflags_q;
    frm_d    = frm_q;
    if (en_i) begin
      if (is_csr_op) begin
        case (dec_i.csr_addr)
          CsrFflags: fflags_d = wdata[4:0];
          CsrFrm:    frm_d    = wdata[2:0];
          CsrFcsr: begin
            frm_d    = wdata[7:5];
            fflags_d = wdata[4:0];
          end
          default: ;
        endcase
      end else begin
        // Flags accumulate until software clears them
        fflags_d = fflags_q | flags_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else begin
      fflags_q <= fflags_d;
      frm_q    <= frm_d;
    end
  end

endmodule

//--- source/fpss_retire.sv
module fpss_retire (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               head_valid_i,
  input  fpss_pkg::hart_id_t hart_id_i,
  input  fpss_pkg::decoded_t dec_i,
  input  fpss_pkg::word_t    int_result_i,
  input  fpss_pkg::word_t    csr_rdata_i,
  output logic               pop_o,
  output logic               fpr_we_o,
  output logic               csr_en_o,
  output logic               c_p_valid_o,
  output fpss_pkg::resp_t    c_p_resp_o,
  input  logic               c_p_ready_i
);
  import fpss_pkg::*;

  logic  illegal;
  logic  is_csr_op;
  logic  need_resp;
  logic  resp_free;
  logic  issue;
  resp_t resp_d;

  assign illegal   = (dec_i.op == OpIllegal);
  assign is_csr_op = (dec_i.op == OpCsrRw) || (dec_i.op == OpCsrRs) ||
                     (dec_i.op == OpCsrRc);
  assign need_resp = !dec_i.rd_is_fp || illegal;

  // Response slot is free when empty or drained this cycle
  assign resp_free = !c_p_valid_o || c_p_ready_i;
  assign issue     = head_valid_i && (!need_resp || resp_free);

  assign pop_o    = issue;
  assign fpr_we_o = issue && dec_i.rd_is_fp && !illegal;
  assign csr_en_o = issue && !illegal;

  always_comb begin
    resp_d.rd      = dec_i.rd;
    resp_d.hart_id = hart_id_i;
    resp_d.error   = illegal;
    if (illegal) begin
      resp_d.data = '0;
    end else if (is_csr_op) begin
      resp_d.data = csr_rdata_i;
    end else begin
      resp_d.data = int_result_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      c_p_valid_o <= 1'b0;
    end else if (issue && need_resp) begin
      c_p_valid_o <= 1'b1;
    end else if (c_p_ready_i) begin
      c_p_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue && need_resp) begin
      c_p_resp_o <= resp_d;
    end
  end

  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    c_p_valid_o && !c_p_ready_i |=> c_p_valid_o && $stable(c_p_resp_o));

endmodule

//--- source/fpss_top.sv
module fpss_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   c_q_valid_i,
  input  fpss_pkg::offload_req_t c_q_req_i,
  output logic                   c_q_ready_o,
  output logic                   c_p_valid_o,
  output fpss_pkg::resp_t        c_p_resp_o,
  input  logic                   c_p_ready_i
);
  import fpss_pkg::*;

  logic         head_valid;
  offload_req_t head;
  logic         pop;
  decoded_t     dec;
  word_t        rdata_a;
  word_t        rdata_b;
  word_t        fp_result;
  word_t        int_result;
  fflags_t      flags;
  word_t        csr_rdata;
  logic         fpr_we;
  logic         csr_en;

  fpss_offload_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (c_q_valid_i),
    .push_i       (c_q_req_i),
    .push_ready_o (c_q_ready_o),
    .head_valid_o (head_valid),
    .head_o       (head),
    .pop_i        (pop)
  );

  fpss_decoder u_decoder (
    .instr_i   (head.instr),
    .rs1_val_i (head.rs1_val),
    .dec_o     (dec)
  );

  // Results always land in the decoded rd
  fpss_regfile u_regfile (
    .clk_i     (clk_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (fpr_we),
    .waddr_i   (dec.rd),
    .wdata_i   (fp_result)
  );

  fpss_exec u_exec (
    .dec_i        (dec),
    .op_a_i       (rdata_a),
    .op_b_i       (rdata_b),
    .fp_result_o  (fp_result),
    .int_result_o (int_result),
    .flags_o      (flags)
  );

  fpss_csr u_csr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (csr_en),
    .dec_i   (dec),
    .flags_i (flags),
    .rdata_o (csr_rdata)
  );

  fpss_retire u_retire (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_valid_i (head_valid),
    .hart_id_i    (head.hart_id),
    .dec_i        (dec),
    .int_result_i (int_result),
    .csr_rdata_i  (csr_rdata),
    .pop_o        (pop),
    .fpr_we_o     (fpr_we),
    .csr_en_o     (csr_en),
    .c_p_valid_o  (c_p_valid_o),
    .c_p_resp_o   (c_p_resp_o),
    .c_p_ready_i  (c_p_ready_i)
  );

endmodule

//--- test/fpss_tb.sv
module fpss_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fpss_pkg::*;

  localparam int ClkPeriod  = 40;
  localparam int DriveDelay = 5;
  localparam int DrainLimit = 100;
  localparam logic [31:0] Seed = 32'h04dd363c;

  logic         clk_i;
  logic         rst_ni;
  logic         c_q_valid_i;
  offload_req_t c_q_req_i;
  logic         c_q_ready_o;
  logic         c_p_valid_o;
  resp_t        c_p_resp_o;
  logic         c_p_ready_i;

  // Stimulus table with one entry per test
  string    name_tab[$];
  word_t    instr_tab[$];
  word_t    rs1_tab[$];
  bit       resp_tab[$];
  word_t    data_tab[$];
  bit       err_tab[$];
  hart_id_t hart_tab[$];

  int expect_q[$];
  bit table_built;
  bit test_bad;
  int pass_count;
  int fail_count;
  int error_count;

  fpss_top DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .c_q_valid_i (c_q_valid_i),
    .c_q_req_i   (c_q_req_i),
    .c_q_ready_o (c_q_ready_o),
    .c_p_valid_o (c_p_valid_o),
    .c_p_resp_o  (c_p_resp_o),
    .c_p_ready_i (c_p_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic word_t fp_instr(logic [6:0] funct7, int rs2, int rs1,
                                     logic [2:0] funct3, int rd);
    return {funct7, reg_addr_t'(rs2), reg_addr_t'(rs1), funct3, reg_addr_t'(rd), OpcodeOpFp};
  endfunction

  // Integer value travels in rs1_val and not in the source field
  function automatic word_t csr_instr(csr_addr_t csr, logic [2:0] funct3, int rd);
    return {csr, 5'd1, funct3, reg_addr_t'(rd), OpcodeSystem};
  endfunction

  task automatic add_test(string name, word_t instr, word_t rs1_val, bit has_resp,
                          word_t data, bit error);
    name_tab.push_back(name);
    instr_tab.push_back(instr);
    rs1_tab.push_back(rs1_val);
    resp_tab.push_back(has_resp);
    data_tab.push_back(data);
    err_tab.push_back(error);
    hart_tab.push_back($urandom());
  endtask

  task automatic load_reg(string name, int fd, word_t value);
    add_test(name, fp_instr(Funct7FmvWX, 0, 1, 3'b000, fd), value, 1'b0, '0, 1'b0);
  endtask

  task automatic read_reg(string name, int fs, word_t expected);
    add_test(name, fp_instr(Funct7FmvXW, 0, fs, 3'b000, fs), '0, 1'b1, expected, 1'b0);
  endtask

  task automatic fp_op(string name, logic [6:0] funct7, logic [2:0] funct3,
                       int fd, int fs1, int fs2);
    add_test(name, fp_instr(funct7, fs2, fs1, funct3, fd), '0, 1'b0, '0, 1'b0);
  endtask

  task automatic cmp_op(string name, logic [2:0] funct3, int fs1, int fs2, word_t expected);
    add_test(name, fp_instr(Funct7Fcmp, fs2, fs1, funct3, 9), '0, 1'b1, expected, 1'b0);
  endtask

  task automatic csr_op(string name, logic [2:0] funct3, csr_addr_t csr, word_t value,
                        word_t old_value);
    add_test(name, csr_instr(csr, funct3, 11), value, 1'b1, old_value, 1'b0);
  endtask

  task automatic build_table();
    load_reg("fmv_w_x_one", 1, 32'h3F80_0000);
    read_reg("fmv_x_w_one", 1, 32'h3F80_0000);
    load_reg("fmv_w_x_minus_two", 2, 32'hC000_0000);
    fp_op("fsgnj", Funct7Fsgnj, 3'b000, 3, 1, 2);
    read_reg("fsgnj_read", 3, 32'hBF80_0000);
    fp_op("fsgnjn", Funct7Fsgnj, 3'b001, 4, 1, 2);
    read_reg("fsgnjn_read", 4, 32'h3F80_0000);
    fp_op("fsgnjx", Funct7Fsgnj, 3'b010, 5, 2, 2);
    read_reg("fsgnjx_read", 5, 32'h4000_0000);
    load_reg("load_minus_zero", 6, 32'h8000_0000);
    load_reg("load_plus_zero", 7, 32'h0000_0000);
    fp_op("fmin_zeros", Funct7Fminmax, 3'b000, 8, 6, 7);
    read_reg("fmin_zeros_read", 8, 32'h8000_0000);
    fp_op("fmax_zeros", Funct7Fminmax, 3'b001, 9, 6, 7);
    read_reg("fmax_zeros_read", 9, 32'h0000_0000);
    // Quiet NaN with a payload, so it differs from the canonical one
    load_reg("load_qnan", 10, 32'h7FC0_0042);
    fp_op("fmin_one_nan", Funct7Fminmax, 3'b000, 11, 10, 1);
    read_reg("fmin_one_nan_read", 11, 32'h3F80_0000);
    load_reg("load_other_qnan", 14, 32'hFFC0_1234);
    fp_op("fmax_two_nan", Funct7Fminmax, 3'b001, 13, 10, 14);
    read_reg("fmax_two_nan_read", 13, 32'h7FC0_0000);
    fp_op("fmin_numbers", Funct7Fminmax, 3'b000, 15, 1, 2);
    read_reg("fmin_numbers_read", 15, 32'hC000_0000);
    cmp_op("feq_equal", 3'b010, 1, 1, 32'd1);
    cmp_op("flt_true", 3'b001, 2, 1, 32'd1);
    cmp_op("fle_false", 3'b000, 1, 2, 32'd0);
    cmp_op("feq_qnan", 3'b010, 10, 1, 32'd0);
    csr_op("fflags_after_feq_qnan", 3'b010, CsrFflags, '0, 32'h00);
    cmp_op("flt_qnan", 3'b001, 10, 1, 32'd0);
    csr_op("fflags_after_flt_qnan", 3'b010, CsrFflags, '0, 32'h10);
    csr_op("fflags_clear_nv", 3'b011, CsrFflags, 32'h10, 32'h10);
    csr_op("fflags_cleared", 3'b010, CsrFflags, '0, 32'h00);
    cmp_op("fle_qnan", 3'b000, 1, 10, 32'd0);
    csr_op("fflags_after_fle_qnan", 3'b011, CsrFflags, 32'h10, 32'h10);
    load_reg("load_snan", 12, 32'h7F80_0001);
    cmp_op("feq_snan", 3'b010, 12, 1, 32'd0);
    csr_op("fflags_after_feq_snan", 3'b011, CsrFflags, 32'h1F, 32'h10);
    csr_op("frm_write", 3'b001, CsrFrm, 32'd3, 32'd0);
    csr_op("fflags_write", 3'b001, CsrFflags, 32'h01, 32'h00);
    csr_op("fcsr_read", 3'b010, CsrFcsr, '0, 32'h61);
    add_test("illegal_fadd", fp_instr(7'b0000000, 2, 1, 3'b000, 7), '0, 1'b1, '0, 1'b1);
    add_test("illegal_csr", csr_instr(12'h300, 3'b010, 8), '0, 1'b1, '0, 1'b1);
    csr_op("frm_restore", 3'b001, CsrFrm, 32'd0, 32'd3);
  endtask

  task automatic compare_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("Fail %s data: expected %h, actual %h", name, expected, actual);
      error_count++;
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_rd(string name, reg_addr_t expected, reg_addr_t actual);
    if (actual !== expected) begin
      $display("Fail %s rd: expected %0d, actual %0d", name, expected, actual);
      error_count++;
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_hart(string name, hart_id_t expected, hart_id_t actual);
    if (actual !== expected) begin
      $display("Fail %s hart id: expected %h, actual %h", name, expected, actual);
      error_count++;
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Fail %s error bit: expected %b, actual %b", name, expected, actual);
      error_count++;
      test_bad = 1'b1;
    end
  endtask

  // Request driver and end of run
  initial begin : driver
    int i;
    int drain;
    rst_ni      = 1'b0;
    c_q_valid_i = 1'b0;
    c_q_req_i   = '0;
    c_p_ready_i = 1'b0;
    void'($urandom(Seed));
    build_table();
    table_built = 1'b1;
    repeat (2) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;
    @(posedge clk_i);
    for (i = 0; i < name_tab.size(); i++) begin
      #(DriveDelay);
      c_q_req_i.instr   = instr_tab[i];
      c_q_req_i.rs1_val = rs1_tab[i];
      c_q_req_i.hart_id = hart_tab[i];
      c_q_valid_i       = 1'b1;
      if (resp_tab[i]) begin
        expect_q.push_back(i);
      end
      // Ready seen at the falling edge holds through the next rising edge
      do @(negedge clk_i); while (!c_q_ready_o);
      @(posedge clk_i);
      if (!resp_tab[i]) begin
        $display("Done %s (no response)", name_tab[i]);
        pass_count++;
      end
    end
    #(DriveDelay);
    c_q_valid_i = 1'b0;
    drain = 0;
    while (expect_q.size() != 0 && drain < DrainLimit) begin
      @(posedge clk_i);
      drain++;
    end
    if (expect_q.size() != 0) begin
      $display("%0d expected responses never arrived", expect_q.size());
      error_count += expect_q.size();
      fail_count  += expect_q.size();
    end
    repeat (4) @(posedge clk_i);
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, error_count);
    if (error_count == 0 && fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Random back-pressure on the response channel
  initial begin
    wait (rst_ni);
    forever begin
      @(posedge clk_i);
      #(DriveDelay);
      c_p_ready_i = ($urandom_range(3, 0) != 0);
    end
  end

  initial begin : monitor
    int idx;
    forever begin
      @(negedge clk_i);
      if (rst_ni && c_p_valid_o && c_p_ready_i) begin
        if (expect_q.size() == 0) begin
          $display("Unexpected response with rd %0d and data %h", c_p_resp_o.rd,
                   c_p_resp_o.data);
          error_count++;
        end else begin
          idx      = expect_q.pop_front();
          test_bad = 1'b0;
          compare_word(name_tab[idx], data_tab[idx], c_p_resp_o.data);
          compare_rd(name_tab[idx], instr_tab[idx][11:7], c_p_resp_o.rd);
          compare_hart(name_tab[idx], hart_tab[idx], c_p_resp_o.hart_id);
          compare_flag(name_tab[idx], err_tab[idx], c_p_resp_o.error);
          if (test_bad) begin
            $display("Test %s failed", name_tab[idx]);
            fail_count++;
          end else begin
            $display("Done %s", name_tab[idx]);
            pass_count++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (table_built);
    #(name_tab.size() * 20 * ClkPeriod);
    $display("Timeout: the run did not finish in %0d cycles", name_tab.size() * 20);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- all.f
source/fpss_pkg.sv
source/fpss_offload_fifo.sv
source/fpss_decoder.sv
source/fpss_regfile.sv
source/fpss_exec.sv
source/fpss_csr.sv
source/fpss_retire.sv
source/fpss_top.sv
test/fpss_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fpss_tb
RTL_TOP   ?= fpss_top
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FLIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
